// ==== vlog.f ====
rtl/noc_reduction_pkg.sv
rtl/alu_cmd_pkg.sv
rtl/alu_cmd_if.sv
rtl/offload_req_decoder.sv
rtl/alu_cmd_fifo.sv
rtl/reduction_alu.sv
rtl/reduction_offload_tile.sv
sim/reduction_offload_properties.sv
sim/reduction_offload_tile_tb.sv

// ==== sim/reduction_offload_tile_tb.sv ====
// Reduction offload tile testbench
// Directed and LFSR driven requests, random response back-pressure,
// in-order result checking against a reference model

`timescale 1ns/10ps

module reduction_offload_tile_tb;

  localparam int unsigned DataWidth   = noc_reduction_pkg::DefaultDataWidth;
  localparam int unsigned FifoDepth   = 4;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned NumDirected = 12;
  localparam int unsigned NumBurst    = 40;
  localparam int unsigned NumStress   = 120;
  localparam int unsigned NumReqs     = NumDirected + NumBurst + NumStress;

  logic                             clk_i;
  logic                             arst_n_i;
  logic                             req_valid_i;
  logic                             req_ready_o;
  noc_reduction_pkg::reduction_op_e req_op_i;
  logic [DataWidth-1:0]             req_operand_a_i;
  logic [DataWidth-1:0]             req_operand_b_i;
  logic                             resp_valid_o;
  logic                             resp_ready_i;
  logic [DataWidth-1:0]             resp_result_o;

  logic [31:0]          lfsr_state = 32'hfbc7;
  logic [DataWidth-1:0] expected_q[$];
  int unsigned          errors = 0;
  int unsigned          accepted_count = 0;
  int unsigned          resp_count = 0;
  int unsigned          ready_drops = 0;
  int unsigned          stall_left = 0;
  logic                 req_taken = 1'b0;
  logic                 random_bp = 1'b0;

  reduction_offload_tile #(
    .DataWidth       (DataWidth),
    .FifoDepth       (FifoDepth)
  ) reduction_offload_tile_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_operand_a_i (req_operand_a_i),
    .req_operand_b_i (req_operand_b_i),
    .resp_valid_o    (resp_valid_o),
    .resp_ready_i    (resp_ready_i),
    .resp_result_o   (resp_result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic draw_bits(input int unsigned n, output logic [63:0] value);
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[62:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [DataWidth-1:0] expected_result(input logic [2:0] op,
                                                           input logic [DataWidth-1:0] a,
                                                           input logic [DataWidth-1:0] b);
    case (op)
      3'd0: return a + b;
      3'd1: return a * b;
      3'd2: return ($signed(a) > $signed(b)) ? a : b;
      3'd3: return ($signed(a) < $signed(b)) ? a : b;
      default: return '0;
    endcase
  endfunction

  task automatic check_result(input logic [DataWidth-1:0] expected,
                              input logic [DataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] resp_result_o expected 0x%h actual 0x%h", expected, actual);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Monitor and compare
  ////////////////////////////////////////

  // Sampled mid-cycle where every signal is settled
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (resp_valid_o && accepted_count == 0) begin
        $display("Response valid before any request was accepted");
        errors++;
      end
      if (req_valid_i && req_ready_o) begin
        expected_q.push_back(expected_result(req_op_i, req_operand_a_i, req_operand_b_i));
        accepted_count++;
        req_taken = 1'b1;
      end
      if (!req_ready_o) begin
        ready_drops++;
      end
      if (resp_valid_o && resp_ready_i) begin
        resp_count++;
        if (expected_q.size() == 0) begin
          $display("Response arrived with no request outstanding");
          errors++;
        end else begin
          check_result(expected_q.pop_front(), resp_result_o);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Advances one cycle and picks resp_ready_i for the new cycle
  task automatic tick();
    logic [63:0] r;
    @(posedge clk_i);
    #1;
    if (!random_bp) begin
      resp_ready_i = 1'b1;
    end else if (stall_left > 0) begin
      stall_left--;
      resp_ready_i = 1'b0;
    end else begin
      draw_bits(4, r);
      if (r[3:0] == 4'd0) begin
        draw_bits(4, r);
        stall_left   = 16 + r[3:0];
        resp_ready_i = 1'b0;
      end else begin
        resp_ready_i = r[0] | r[1];
      end
    end
  endtask

  task automatic idle(input int unsigned cycles);
    req_valid_i = 1'b0;
    repeat (cycles) tick();
  endtask

  task automatic send_request(input logic [2:0] op,
                              input logic [DataWidth-1:0] a,
                              input logic [DataWidth-1:0] b);
    req_op_i        = noc_reduction_pkg::reduction_op_e'(op);
    req_operand_a_i = a;
    req_operand_b_i = b;
    req_valid_i     = 1'b1;
    req_taken       = 1'b0;
    do begin
      tick();
    end while (!req_taken);
    req_taken   = 1'b0;
    req_valid_i = 1'b0;
  endtask

  task automatic send_random();
    logic [63:0]          r;
    logic [2:0]           op;
    logic [DataWidth-1:0] a;
    draw_bits(3, r);
    op = r[2:0];
    draw_bits(DataWidth, r);
    a = r[DataWidth-1:0];
    draw_bits(DataWidth, r);
    send_request(op, a, r[DataWidth-1:0]);
  endtask

  initial begin : drive
    logic [63:0]          r;
    logic [DataWidth-1:0] ones;
    logic [DataWidth-1:0] min_neg;
    logic [DataWidth-1:0] max_pos;
    ones            = '1;
    min_neg         = {1'b1, {(DataWidth - 1){1'b0}}};
    max_pos         = ~min_neg;
    arst_n_i        = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = noc_reduction_pkg::RD_ADD;
    req_operand_a_i = '0;
    req_operand_b_i = '0;
    resp_ready_i    = 1'b1;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    idle(5);

    // Wraparound, signed compare, unsupported codes
    send_request(3'd0, ones, DataWidth'(2));
    send_request(3'd0, min_neg, min_neg);
    send_request(3'd1, ones, ones);
    send_request(3'd1, max_pos, DataWidth'(2));
    send_request(3'd2, ones, DataWidth'(1));
    send_request(3'd3, ones, DataWidth'(1));
    send_request(3'd2, min_neg, max_pos);
    send_request(3'd3, min_neg, max_pos);
    for (int unsigned op = 4; op < 8; op++) begin
      send_request(3'(op), ones, max_pos);
    end

    // Back-to-back with the response side always ready
    repeat (NumBurst) send_random();

    random_bp = 1'b1;
    repeat (NumStress) begin
      draw_bits(3, r);
      if (r[2:0] > 3'd4) begin
        idle(r[2:0] - 3'd4);
      end
      send_random();
    end

    random_bp  = 1'b0;
    stall_left = 0;
    while (resp_count < accepted_count) begin
      tick();
    end
    idle(3);

    if (expected_q.size() != 0) begin
      $display("%0d expected results were never returned", expected_q.size());
      errors++;
    end
    if (ready_drops == 0) begin
      $display("req_ready_o never dropped under back-pressure");
      errors++;
    end
    $display("Errors: %0d, requests: %0d, responses: %0d",
             errors, accepted_count, resp_count);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #((NumReqs * (FifoDepth + 10) + ResetCycles) * 10);
    $display("Timeout: the DUT stopped answering before all requests completed");
    $display("Test failed");
    $finish;
  end

endmodule

// ==== sim/reduction_offload_properties.sv ====
// Reduction offload response checks
// Handshake rules on the response port of the offload tile

`timescale 1ns/10ps

module reduction_offload_properties #(
  parameter int unsigned DataWidth = noc_reduction_pkg::DefaultDataWidth
) (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 resp_valid_o,
  input logic                 resp_ready_i,
  input logic [DataWidth-1:0] resp_result_o
);

  // Stalled result must not change
  property result_stable_p;
    @(posedge clk_i) disable iff (!arst_n_i)
      resp_valid_o && !resp_ready_i |=> $stable(resp_result_o);
  endproperty

  // Valid holds until the transfer
  property valid_held_p;
    @(posedge clk_i) disable iff (!arst_n_i)
      resp_valid_o && !resp_ready_i |=> resp_valid_o;
  endproperty

  // Nothing to return right after reset
  property valid_low_after_reset_p;
    @(posedge clk_i) $rose(arst_n_i) |-> !resp_valid_o;
  endproperty

  result_stable_a : assert property (result_stable_p)
    else $error("resp_result_o changed while the response was stalled");

  valid_held_a : assert property (valid_held_p)
    else $error("resp_valid_o dropped before its transfer");

  valid_low_after_reset_a : assert property (valid_low_after_reset_p)
    else $error("resp_valid_o high in the cycle after reset");

endmodule

bind reduction_offload_tile reduction_offload_properties #(
  .DataWidth     (DataWidth)
) reduction_offload_properties_i (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .resp_valid_o  (resp_valid_o),
  .resp_ready_i  (resp_ready_i),
  .resp_result_o (resp_result_o)
);

// ==== rtl/reduction_offload_tile.sv ====
// Reduction offload tile
// Decodes reduction requests into ALU commands, buffers them
// and returns the integer reduction result with valid/ready

`timescale 1ns/10ps

module reduction_offload_tile #(
  parameter int unsigned DataWidth = noc_reduction_pkg::DefaultDataWidth,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // Request side
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  noc_reduction_pkg::reduction_op_e req_op_i,
  input  logic [DataWidth-1:0]             req_operand_a_i,
  input  logic [DataWidth-1:0]             req_operand_b_i,
  // Response side
  output logic                             resp_valid_o,
  input  logic                             resp_ready_i,
  output logic [DataWidth-1:0]             resp_result_o
);

  // Decoder to FIFO
  alu_cmd_if #(.DataWidth(DataWidth)) dec_cmd ();

  // FIFO to ALU
  alu_cmd_if #(.DataWidth(DataWidth)) alu_cmd ();

  ////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////

  offload_req_decoder #(
    .DataWidth       (DataWidth)
  ) offload_req_decoder_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_operand_a_i (req_operand_a_i),
    .req_operand_b_i (req_operand_b_i),
    .cmd_o           (dec_cmd.producer)
  );

  ////////////////////////////////////////
  // Command buffer
  ////////////////////////////////////////

  alu_cmd_fifo #(
    .DataWidth (DataWidth),
    .FifoDepth (FifoDepth)
  ) alu_cmd_fifo_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .cmd_i     (dec_cmd.consumer),
    .cmd_o     (alu_cmd.producer)
  );

  ////////////////////////////////////////
  // Reduction ALU
  ////////////////////////////////////////

  reduction_alu #(
    .DataWidth     (DataWidth)
  ) reduction_alu_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cmd_i         (alu_cmd.consumer),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_result_o (resp_result_o)
  );

endmodule

// ==== rtl/reduction_alu.sv ====
// Integer reduction ALU
// Executes add, multiply and signed min/max on two operands
// and holds the result in a one-entry register until taken

`timescale 1ns/10ps

module reduction_alu #(
  parameter int unsigned DataWidth = noc_reduction_pkg::DefaultDataWidth
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  alu_cmd_if.consumer          cmd_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output logic [DataWidth-1:0] resp_result_o
);

  logic [DataWidth-1:0] sum;
  logic [DataWidth-1:0] product;
  logic [DataWidth-1:0] max_val;
  logic [DataWidth-1:0] min_val;
  logic [DataWidth-1:0] result_d;
  logic [DataWidth-1:0] result_q;
  logic                 a_gt_b;
  logic                 resp_valid_q;
  logic                 cmd_accept;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Both wrap to DataWidth bits
  assign sum     = cmd_i.operand_a + cmd_i.operand_b;
  assign product = cmd_i.operand_a * cmd_i.operand_b;

  // Two's complement compare
  assign a_gt_b  = $signed(cmd_i.operand_a) > $signed(cmd_i.operand_b);
  assign max_val = a_gt_b ? cmd_i.operand_a : cmd_i.operand_b;
  assign min_val = a_gt_b ? cmd_i.operand_b : cmd_i.operand_a;

  always_comb begin
    case (cmd_i.opcode)
      alu_cmd_pkg::ALU_ADD: result_d = sum;
      alu_cmd_pkg::ALU_MUL: result_d = product;
      alu_cmd_pkg::ALU_MINMAX: begin
        if (cmd_i.minmax_sel == alu_cmd_pkg::SEL_MIN) begin
          result_d = min_val;
        end else begin
          result_d = max_val;
        end
      end
      default: result_d = '0;
    endcase
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  // Takes a new command when empty or when the result leaves now
  assign cmd_i.ready = ~resp_valid_q | resp_ready_i;
  assign cmd_accept  = cmd_i.valid & cmd_i.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (cmd_accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Frozen while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      result_q <= result_d;
    end
  end

  assign resp_valid_o  = resp_valid_q;
  assign resp_result_o = result_q;

endmodule

// ==== rtl/alu_cmd_fifo.sv ====
// ALU command FIFO
// Circular buffer of FifoDepth commands between decoder and ALU
// Output is registered so a write into an empty FIFO shows a cycle later

`timescale 1ns/10ps

module alu_cmd_fifo #(
  parameter int unsigned DataWidth = noc_reduction_pkg::DefaultDataWidth,
  parameter int unsigned FifoDepth = 4
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  alu_cmd_if.consumer cmd_i,
  alu_cmd_if.producer cmd_o
);

  localparam int unsigned PtrWidth   = $clog2(FifoDepth);
  localparam int unsigned CountWidth = $clog2(FifoDepth + 1);

  // Storage
  alu_cmd_pkg::alu_opcode_e opcode_mem    [FifoDepth];
  alu_cmd_pkg::minmax_sel_e sel_mem       [FifoDepth];
  logic [DataWidth-1:0]     operand_a_mem [FifoDepth];
  logic [DataWidth-1:0]     operand_b_mem [FifoDepth];

  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CountWidth-1:0] count_q;
  logic                  push;
  logic                  pop;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  assign cmd_i.ready = (count_q != CountWidth'(FifoDepth));
  assign cmd_o.valid = (count_q != '0);

  assign push = cmd_i.valid & cmd_i.ready;
  assign pop  = cmd_o.valid & cmd_o.ready;

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PtrWidth'(1);
      end
      if (push && !pop) begin
        count_q <= count_q + CountWidth'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CountWidth'(1);
      end
    end
  end

  ////////////////////////////////////////
  // Buffer
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      opcode_mem[wr_ptr_q]    <= cmd_i.opcode;
      sel_mem[wr_ptr_q]       <= cmd_i.minmax_sel;
      operand_a_mem[wr_ptr_q] <= cmd_i.operand_a;
      operand_b_mem[wr_ptr_q] <= cmd_i.operand_b;
    end
  end

  // Head entry
  assign cmd_o.opcode     = opcode_mem[rd_ptr_q];
  assign cmd_o.minmax_sel = sel_mem[rd_ptr_q];
  assign cmd_o.operand_a  = operand_a_mem[rd_ptr_q];
  assign cmd_o.operand_b  = operand_b_mem[rd_ptr_q];

endmodule

// ==== rtl/offload_req_decoder.sv ====
// Offload request decoder
// Maps reduction operations to ALU commands in a one-entry
// register stage that holds its command until it is taken

`timescale 1ns/10ps

module offload_req_decoder #(
  parameter int unsigned DataWidth = noc_reduction_pkg::DefaultDataWidth
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  noc_reduction_pkg::reduction_op_e  req_op_i,
  input  logic [DataWidth-1:0]              req_operand_a_i,
  input  logic [DataWidth-1:0]              req_operand_b_i,
  alu_cmd_if.producer                       cmd_o
);

  alu_cmd_pkg::alu_opcode_e opcode_d, opcode_q;
  alu_cmd_pkg::minmax_sel_e sel_d, sel_q;
  logic [DataWidth-1:0]     operand_a_d, operand_a_q;
  logic [DataWidth-1:0]     operand_b_d, operand_b_q;
  logic                     cmd_valid_q;
  logic                     req_accept;

  ////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////

  always_comb begin
    opcode_d    = alu_cmd_pkg::ALU_ADD;
    sel_d       = alu_cmd_pkg::SEL_MAX;
    operand_a_d = req_operand_a_i;
    operand_b_d = req_operand_b_i;
    case (req_op_i)
      noc_reduction_pkg::RD_ADD: opcode_d = alu_cmd_pkg::ALU_ADD;
      noc_reduction_pkg::RD_MUL: opcode_d = alu_cmd_pkg::ALU_MUL;
      noc_reduction_pkg::RD_MAX: begin
        opcode_d = alu_cmd_pkg::ALU_MINMAX;
        sel_d    = alu_cmd_pkg::SEL_MAX;
      end
      noc_reduction_pkg::RD_MIN: begin
        opcode_d = alu_cmd_pkg::ALU_MINMAX;
        sel_d    = alu_cmd_pkg::SEL_MIN;
      end
      // Unsupported code adds two zeros
      default: begin
        operand_a_d = '0;
        operand_b_d = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Command register
  ////////////////////////////////////////

  // Free when empty or when the FIFO drains it this cycle
  assign req_ready_o = ~cmd_valid_q | cmd_o.ready;
  assign req_accept  = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_valid_q <= 1'b0;
    end else if (req_accept) begin
      cmd_valid_q <= 1'b1;
    end else if (cmd_o.ready) begin
      cmd_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      opcode_q    <= opcode_d;
      sel_q       <= sel_d;
      operand_a_q <= operand_a_d;
      operand_b_q <= operand_b_d;
    end
  end

  assign cmd_o.valid      = cmd_valid_q;
  assign cmd_o.opcode     = opcode_q;
  assign cmd_o.minmax_sel = sel_q;
  assign cmd_o.operand_a  = operand_a_q;
  assign cmd_o.operand_b  = operand_b_q;

endmodule

// ==== rtl/alu_cmd_if.sv ====
// ALU command channel
// One decoded command with operands and a valid/ready handshake

`timescale 1ns/10ps

interface alu_cmd_if #(
  parameter int unsigned DataWidth = noc_reduction_pkg::DefaultDataWidth
);

  logic                     valid;
  logic                     ready;
  alu_cmd_pkg::alu_opcode_e opcode;
  alu_cmd_pkg::minmax_sel_e minmax_sel;
  logic [DataWidth-1:0]     operand_a;
  logic [DataWidth-1:0]     operand_b;

  // Drives the command and waits for ready
  modport producer (
    output valid,
    output opcode,
    output minmax_sel,
    output operand_a,
    output operand_b,
    input  ready
  );

  // Takes the command when ready
  modport consumer (
    input  valid,
    input  opcode,
    input  minmax_sel,
    input  operand_a,
    input  operand_b,
    output ready
  );

endinterface

// ==== rtl/alu_cmd_pkg.sv ====
// Datapath ALU command definitions
// Opcodes of the integer reduction ALU and the min/max select

package alu_cmd_pkg;

  ////////////////////////////////////////
  // ALU opcodes
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_MUL    = 2'd1,
    ALU_MINMAX = 2'd2
  } alu_opcode_e;

  ////////////////////////////////////////
  // Min/max select
  ////////////////////////////////////////

  // Picks which operand the MINMAX opcode returns
  typedef enum logic {
    SEL_MAX = 1'b0,
    SEL_MIN = 1'b1
  } minmax_sel_e;

endpackage

// ==== rtl/noc_reduction_pkg.sv ====
// Network-side reduction definitions
// Operation codes as they arrive on the offload request port
// and the default operand width of the offload path

package noc_reduction_pkg;

  // Operand width of the narrow reduction path
  localparam int unsigned DefaultDataWidth = 32;

  ////////////////////////////////////////
  // Reduction operations
  ////////////////////////////////////////

  // Codes 4 to 7 are not supported and reduce to zero
  typedef enum logic [2:0] {
    RD_ADD = 3'd0,
    RD_MUL = 3'd1,
    RD_MAX = 3'd2,
    RD_MIN = 3'd3
  } reduction_op_e;

endpackage
